/* common/frame_store_pkg.sv */
package frame_store_pkg;

	// Arcade screen geometry
	localparam int COL_BITS = 8;
	localparam int ROW_BITS = 5;
	localparam int VISIBLE_COLS = 256;
	localparam int VISIBLE_LINES = 224;

	// CPU bus view
	typedef logic [31:0] addr_t;
	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;

	// Byte index into the frame memory, column above byte row
	typedef logic [COL_BITS+ROW_BITS-1:0] mem_addr_t;

	// Video DMA view
	typedef logic [31:0] rgb_t;
	typedef logic [9:0] scan_x_t;
	typedef logic [8:0] scan_y_t;

	// Bus port sequencing
	typedef enum logic [1:0]
	{
		BUS_IDLE = 2'd0,
		BUS_ACCESS = 2'd1,
		BUS_HOLD = 2'd2
	} bus_state_e;

	// White with the alpha byte left at zero
	localparam rgb_t PIXEL_ON = 32'h00ff_ffff;
	localparam rgb_t PIXEL_OFF = 32'h0000_0000;

	// Frame buffer window in the CPU map
	localparam addr_t DEFAULT_FRAME_BASE = 32'h0100_0000;

endpackage

/* logic/m68k_bus_port.sv */
module m68k_bus_port
#(
	parameter frame_store_pkg::addr_t frame_base = frame_store_pkg::DEFAULT_FRAME_BASE
)
(
	input logic Clock25Mhz,
	input logic arst_n,
	input logic as_n,
	input logic uds_n,
	input logic lds_n,
	input logic rw,
	input frame_store_pkg::addr_t address,
	input frame_store_pkg::word_t data_in,
	output logic dtack_n,
	output frame_store_pkg::word_t data_out,
	output logic cpu_en,
	output logic cpu_we,
	output frame_store_pkg::mem_addr_t cpu_addr,
	output frame_store_pkg::byte_t cpu_wdata,
	input frame_store_pkg::byte_t cpu_rdata
);

	// Offset bits inside the window, the rest must match the base
	localparam int WIN_BITS = $bits(frame_store_pkg::mem_addr_t);

	frame_store_pkg::bus_state_e state;
	frame_store_pkg::bus_state_e state_next;
	logic in_window;
	logic strobe;
	logic start;

	// Window decode on the upper address bits
	assign in_window = (address[31:WIN_BITS] == frame_base[31:WIN_BITS]);
	assign strobe = ~uds_n | ~lds_n;

	// New access only from idle
	assign start = (state == frame_store_pkg::BUS_IDLE) & ~as_n & in_window & strobe;

	// Memory sees exactly one enable per strobe
	assign cpu_en = start;
	assign cpu_we = start & ~rw;
	assign cpu_addr = address[WIN_BITS-1:0];
	// Only the low lane is stored
	assign cpu_wdata = data_in[7:0];

	// Next state
	always_comb
	begin
		state_next = state;
		case (state)
			frame_store_pkg::BUS_IDLE:
			begin
				if (start)
				begin
					state_next = frame_store_pkg::BUS_ACCESS;
				end
			end
			frame_store_pkg::BUS_ACCESS:
			begin
				// Strobe may already be gone after the first acknowledged cycle
				if (as_n)
					state_next = frame_store_pkg::BUS_IDLE;
				else
					state_next = frame_store_pkg::BUS_HOLD;
			end
			frame_store_pkg::BUS_HOLD:
			begin
				// Wait for the CPU to end the cycle
				if (as_n)
				begin
					state_next = frame_store_pkg::BUS_IDLE;
				end
			end
			default:
			begin
				state_next = frame_store_pkg::BUS_IDLE;
			end
		endcase
	end

	// State and registered DTACK
	always_ff @(posedge Clock25Mhz or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= frame_store_pkg::BUS_IDLE;
			dtack_n <= 1'b1;
		end
		else
		begin
			state <= state_next;
			// Low for as long as the port is busy
			dtack_n <= (state_next == frame_store_pkg::BUS_IDLE);
		end
	end

	// Returned byte on both lanes while acknowledged
	// Memory output holds because the enable is not repeated
	assign data_out = (state != frame_store_pkg::BUS_IDLE) ? {cpu_rdata, cpu_rdata} : '0;

endmodule

/* video/pixel_fetch.sv */
module pixel_fetch
(
	input logic Clock25Mhz,
	input logic arst_n,
	input logic pix_read,
	input frame_store_pkg::scan_x_t pix_x,
	input frame_store_pkg::scan_y_t pix_y,
	output logic vid_en,
	output frame_store_pkg::mem_addr_t vid_addr,
	input frame_store_pkg::byte_t vid_rdata,
	output logic pix_valid,
	output frame_store_pkg::rgb_t pix_data
);

	logic [frame_store_pkg::COL_BITS-1:0] column;
	logic [7:0] line;
	logic [frame_store_pkg::ROW_BITS-1:0] byte_row;
	logic [2:0] bit_sel;
	logic visible;

	// Side band that travels with the memory read
	logic [2:0] bit_q;
	logic visible_q;

	// Scan doubled in both directions
	assign column = pix_x[frame_store_pkg::COL_BITS:1];
	assign line = pix_y[8:1];

	// Eight lines per byte, lowest bit at the top
	assign byte_row = line[7:3];
	assign bit_sel = line[2:0];

	// Right of 512 or below 224 lines is border
	assign visible = (pix_x < scan_x_width(2 * frame_store_pkg::VISIBLE_COLS))
		& (line < frame_store_pkg::VISIBLE_LINES);

	// Memory request
	assign vid_en = pix_read;
	assign vid_addr = {column, byte_row};

	// Valid pipe
	always_ff @(posedge Clock25Mhz or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pix_valid <= 1'b0;
		end
		else
		begin
			pix_valid <= pix_read;
		end
	end

	// Bit index and visibility
	always_ff @(posedge Clock25Mhz)
	begin
		if (pix_read)
		begin
			bit_q <= bit_sel;
			visible_q <= visible;
		end
	end

	// Colour expansion on the returned byte
	assign pix_data = (visible_q & vid_rdata[bit_q]) ?
		frame_store_pkg::PIXEL_ON : frame_store_pkg::PIXEL_OFF;

	// Constant sized to the scan coordinate
	function automatic frame_store_pkg::scan_x_t scan_x_width(input int value);
		frame_store_pkg::scan_x_t result;
		result = value[$bits(frame_store_pkg::scan_x_t)-1:0];
		return result;
	endfunction

endmodule

/* video/frame_memory.sv */
module frame_memory
#(
	parameter int ADDR_BITS = 13
)
(
	input logic Clock25Mhz,
	input logic cpu_en,
	input logic cpu_we,
	input logic [ADDR_BITS-1:0] cpu_addr,
	input frame_store_pkg::byte_t cpu_wdata,
	output frame_store_pkg::byte_t cpu_rdata,
	input logic vid_en,
	input logic [ADDR_BITS-1:0] vid_addr,
	output frame_store_pkg::byte_t vid_rdata
);

	localparam int DEPTH = 2 ** ADDR_BITS;

	// Block RAM array, contents are not reset
	frame_store_pkg::byte_t mem [DEPTH];

	// CPU port, read before write
	always_ff @(posedge Clock25Mhz)
	begin
		if (cpu_en)
		begin
			cpu_rdata <= mem[cpu_addr];
			if (cpu_we)
			begin
				mem[cpu_addr] <= cpu_wdata;
			end
		end
	end

	// Video port, read only
	// Same-cycle CPU write is not seen here
	always_ff @(posedge Clock25Mhz)
	begin
		if (vid_en)
		begin
			vid_rdata <= mem[vid_addr];
		end
	end

endmodule

/* logic/video_frame_store.sv */
module video_frame_store
#(
	parameter frame_store_pkg::addr_t frame_base = frame_store_pkg::DEFAULT_FRAME_BASE,
	parameter int ADDR_BITS = 13
)
(
	input logic Clock25Mhz,
	input logic arst_n,
	input logic as_n,
	input logic uds_n,
	input logic lds_n,
	input logic rw,
	input frame_store_pkg::addr_t address,
	input frame_store_pkg::word_t data_in,
	output frame_store_pkg::word_t data_out,
	output logic dtack_n,
	input logic pix_read,
	input frame_store_pkg::scan_x_t pix_x,
	input frame_store_pkg::scan_y_t pix_y,
	output logic pix_valid,
	output frame_store_pkg::rgb_t pix_data
);

	// CPU side of the memory
	logic cpu_en;
	logic cpu_we;
	frame_store_pkg::mem_addr_t cpu_addr;
	frame_store_pkg::byte_t cpu_wdata;
	frame_store_pkg::byte_t cpu_rdata;

	// Video side of the memory
	logic vid_en;
	frame_store_pkg::mem_addr_t vid_addr;
	frame_store_pkg::byte_t vid_rdata;

	// 68000 window
	m68k_bus_port #(
		.frame_base(frame_base)
	) u_bus_port (
		.Clock25Mhz(Clock25Mhz),
		.arst_n(arst_n),
		.as_n(as_n),
		.uds_n(uds_n),
		.lds_n(lds_n),
		.rw(rw),
		.address(address),
		.data_in(data_in),
		.dtack_n(dtack_n),
		.data_out(data_out),
		.cpu_en(cpu_en),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata)
	);

	// Pixel DMA adapter
	pixel_fetch u_pixel_fetch (
		.Clock25Mhz(Clock25Mhz),
		.arst_n(arst_n),
		.pix_read(pix_read),
		.pix_x(pix_x),
		.pix_y(pix_y),
		.vid_en(vid_en),
		.vid_addr(vid_addr),
		.vid_rdata(vid_rdata),
		.pix_valid(pix_valid),
		.pix_data(pix_data)
	);

	// Shared frame
	frame_memory #(
		.ADDR_BITS(ADDR_BITS)
	) u_frame_memory (
		.Clock25Mhz(Clock25Mhz),
		.cpu_en(cpu_en),
		.cpu_we(cpu_we),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata),
		.vid_en(vid_en),
		.vid_addr(vid_addr),
		.vid_rdata(vid_rdata)
	);

endmodule

/* sim/tb_clock.sv */
module tb_clock
#(
	parameter int PERIOD_NS = 40,
	parameter int RESET_CYCLES = 4
)
(
	output logic Clock25Mhz,
	output logic arst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// Free running 25 MHz clock
	initial
	begin
		Clock25Mhz = 1'b0;
		forever
			#(PERIOD_NS / 2) Clock25Mhz = ~Clock25Mhz;
	end

	// Reset low over the first rising edges
	initial
	begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clock25Mhz);
		arst_n <= 1'b1;
	end

endmodule

/* sim/frame_checker.sv */
module frame_checker
#(
	parameter frame_store_pkg::addr_t frame_base = frame_store_pkg::DEFAULT_FRAME_BASE
)
(
	input logic Clock25Mhz,
	input logic arst_n,
	input logic as_n,
	input logic uds_n,
	input logic lds_n,
	input logic rw,
	input frame_store_pkg::addr_t address,
	input frame_store_pkg::word_t data_in,
	input frame_store_pkg::word_t data_out,
	input logic dtack_n,
	input logic pix_read,
	input frame_store_pkg::scan_x_t pix_x,
	input frame_store_pkg::scan_y_t pix_y,
	input logic pix_valid,
	input frame_store_pkg::rgb_t pix_data,
	output int error_count,
	output int check_count
);
	timeunit 1ns;
	timeprecision 1ps;

	// Model of the frame, brought to zero by the preload writes
	frame_store_pkg::byte_t model [8192];

	// Expected outputs after the coming rising edge
	logic busy;
	logic exp_dtack_n;
	logic exp_read;
	frame_store_pkg::byte_t exp_byte;
	logic exp_valid;
	logic exp_offscreen;
	frame_store_pkg::rgb_t exp_pix;
	logic in_window;
	int line;
	int index;

	initial
	begin
		error_count = 0;
		check_count = 0;
		for (int i = 0; i < 8192; i++)
			model[i] = '0;
	end

	task automatic report_mismatch(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		error_count++;
		$display("Error %s at %0t ns: expected %h, actual %h", test, $time, expected, actual);
	endtask

	// Sampled at the falling edge where all ports are settled
	always @(negedge Clock25Mhz)
	begin
		if (!arst_n)
		begin
			busy = 1'b0;
			exp_dtack_n = 1'b1;
			exp_read = 1'b0;
			exp_byte = '0;
			exp_valid = 1'b0;
			exp_offscreen = 1'b0;
			exp_pix = '0;
		end
		else
		begin
			// What the last edge should have produced
			check_count++;
			if (dtack_n !== exp_dtack_n)
				report_mismatch("dtack", 32'(exp_dtack_n), 32'(dtack_n));
			if (!exp_dtack_n && exp_read && data_out !== {exp_byte, exp_byte})
				report_mismatch("readback", 32'({exp_byte, exp_byte}), 32'(data_out));
			if (exp_dtack_n && data_out !== '0)
				report_mismatch("data idle", 32'h0, 32'(data_out));
			if (pix_valid !== exp_valid)
				report_mismatch("pix_valid", 32'(exp_valid), 32'(pix_valid));
			else if (exp_valid && pix_data !== exp_pix)
				report_mismatch(exp_offscreen ? "offscreen" : "pixel", exp_pix, pix_data);

			// Video request, sees the byte before any write in the same cycle
			// Scan doubled both ways, 32 byte rows per column, 8 lines per byte
			line = int'(pix_y) / 2;
			index = ((int'(pix_x) / 2) % 256) * 32 + line / 8;
			exp_valid = pix_read;
			exp_offscreen = (int'(pix_x) >= 512) || (line >= 224);
			if (pix_read)
				exp_pix = (!exp_offscreen && model[13'(index)][3'(line % 8)]) ?
					32'h00ff_ffff : 32'h0000_0000;

			// Bus port, one access per strobe, held until as_n rises
			in_window = (address[31:13] == frame_base[31:13]);
			if (!busy && !as_n && in_window && !(uds_n && lds_n))
			begin
				busy = 1'b1;
				exp_read = rw;
				exp_byte = model[address[12:0]];
				// Low lane only
				if (!rw)
					model[address[12:0]] = data_in[7:0];
			end
			else if (busy && as_n)
				busy = 1'b0;
			exp_dtack_n = !busy;
		end
	end

endmodule

/* sim/tb_top.sv */
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam frame_store_pkg::addr_t FRAME_BASE = frame_store_pkg::DEFAULT_FRAME_BASE;
	localparam int unsigned SEED = 32'hca72_0167;
	localparam int WINDOW_BYTES = 8192;
	localparam int BUS_CYCLES = 3000;
	localparam int ACK_LIMIT = 4;
	// Preload and random cycles, at most 8 clocks each
	localparam int WATCHDOG_CYCLES = (WINDOW_BYTES + BUS_CYCLES) * 8 + 100;

	logic Clock25Mhz;
	logic arst_n;
	logic as_n;
	logic uds_n;
	logic lds_n;
	logic rw;
	frame_store_pkg::addr_t address;
	frame_store_pkg::word_t data_in;
	frame_store_pkg::word_t data_out;
	logic dtack_n;
	logic pix_read;
	frame_store_pkg::scan_x_t pix_x;
	frame_store_pkg::scan_y_t pix_y;
	logic pix_valid;
	frame_store_pkg::rgb_t pix_data;
	int error_count;
	int check_count;
	int stall_count;
	logic bus_done;
	frame_store_pkg::addr_t last_write;

	tb_clock u_clock (.*);

	video_frame_store #(.frame_base(FRAME_BASE), .ADDR_BITS(13)) DUT (.*);

	frame_checker #(.frame_base(FRAME_BASE)) u_frame_checker (.*);

	// Waits at falling edges for dtack_n to reach a level
	task automatic wait_dtack(input logic level);
		int cycles;
		cycles = 0;
		do
			@(negedge Clock25Mhz) cycles++;
		while (dtack_n !== level && cycles < ACK_LIMIT);
		if (dtack_n !== level)
		begin
			stall_count++;
			$display("Bus cycle to %h: dtack_n never went to %b within %0d clocks",
				address, level, ACK_LIMIT);
		end
	endtask

	// One 68000 cycle, strobes as {uds_n, lds_n}
	task automatic bus_cycle(input logic rd, input frame_store_pkg::addr_t addr,
		input logic [1:0] strobes, input frame_store_pkg::word_t data, input int hold);
		logic ack;
		ack = (addr[31:13] == FRAME_BASE[31:13]) && (strobes != 2'b11);
		@(posedge Clock25Mhz);
		as_n <= 1'b0;
		rw <= rd;
		address <= addr;
		{uds_n, lds_n} <= strobes;
		data_in <= data;
		if (ack)
			wait_dtack(1'b0);
		// New data while the strobe is still held
		// Only the first cycle of the strobe may write
		@(posedge Clock25Mhz);
		data_in <= ~data;
		repeat (hold) @(posedge Clock25Mhz);
		@(posedge Clock25Mhz);
		as_n <= 1'b1;
		{uds_n, lds_n} <= 2'b11;
		if (ack)
			wait_dtack(1'b1);
	endtask

	task automatic random_bus_cycle();
		logic rd;
		logic [1:0] strobes;
		frame_store_pkg::addr_t addr;
		rd = 1'($urandom_range(0, 1));
		addr = FRAME_BASE + 32'($urandom_range(0, WINDOW_BYTES - 1));
		// Half the reads revisit the last write
		if (rd && $urandom_range(0, 1) == 1)
			addr = last_write;
		// Some cycles fall outside the window
		if ($urandom_range(0, 9) == 0)
			addr = $urandom;
		strobes = 2'($urandom_range(0, 2));
		if ($urandom_range(0, 15) == 0)
			strobes = 2'b11;
		if (!rd)
			last_write = addr;
		bus_cycle(rd, addr, strobes, 16'($urandom), int'($urandom_range(0, 3)));
	endtask

	// Random read bursts, mostly inside the 640x480 scan
	task automatic video_traffic();
		int burst;
		while (!bus_done)
		begin
			burst = int'($urandom_range(1, 12));
			repeat (burst)
			begin
				@(posedge Clock25Mhz);
				pix_read <= 1'b1;
				pix_x <= ($urandom_range(0, 7) == 0) ? 10'($urandom) : 10'($urandom_range(0, 639));
				pix_y <= ($urandom_range(0, 7) == 0) ? 9'($urandom) : 9'($urandom_range(0, 479));
			end
			@(posedge Clock25Mhz);
			pix_read <= 1'b0;
			repeat ($urandom_range(0, 4)) @(posedge Clock25Mhz);
		end
	endtask

	initial
	begin
		void'($urandom(SEED));
		as_n = 1'b1;
		uds_n = 1'b1;
		lds_n = 1'b1;
		rw = 1'b1;
		address = '0;
		data_in = '0;
		pix_read = 1'b0;
		pix_x = '0;
		pix_y = '0;
		stall_count = 0;
		bus_done = 1'b0;
		last_write = FRAME_BASE;
		@(posedge arst_n);
		// Zero every byte so the model starts from known contents
		for (int i = 0; i < WINDOW_BYTES; i++)
			bus_cycle(1'b0, FRAME_BASE + 32'(i), 2'b10, 16'h0000, 0);
		fork
			begin
				repeat (BUS_CYCLES) random_bus_cycle();
				bus_done = 1'b1;
			end
			video_traffic();
		join
		repeat (4) @(posedge Clock25Mhz);
		$display("Closing report: %0d checks, %0d errors, %0d bus stalls",
			check_count, error_count, stall_count);
		if (error_count == 0 && stall_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge Clock25Mhz);
		$display("Watchdog expired after %0d clocks, stimulus did not finish", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* list.f */
common/frame_store_pkg.sv
logic/m68k_bus_port.sv
video/pixel_fetch.sv
video/frame_memory.sv
logic/video_frame_store.sv
sim/tb_clock.sv
sim/frame_checker.sv
sim/tb_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP = tb_top
FILELIST = list.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_PATTERN = TEST PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_PATTERN)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
